// ==== Bender.yml ====
package:
  name: trace_monitor

sources:
  - trace_pkg.sv
  - monitor_pkg.sv
  - r3_checker.sv
  - nop_decoder.sv
  - event_combiner.sv
  - trace_monitor_top.sv
  - target: test
    files:
      - tb_trace_monitor.sv

// ==== event_combiner.sv ====
/*
 * Event combiner: turns nop hits and r3 values into host events,
 * tracks per-core exit and global termination
 */
`timescale 1ns/1ps

module event_combiner (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   // From the per-core decoders
   input  logic [monitor_pkg::NUM_CORES-1:0]     nop_hit_i,
   input  logic [monitor_pkg::NUM_CORES-1:0][trace_pkg::NOP_CODE_W-1:0]
                                                 nop_code_i,
   // From the per-core r3 shadows
   input  logic [monitor_pkg::NUM_CORES-1:0][trace_pkg::TRACE_DATA_W-1:0]
                                                 r3_i,
   // Host events
   output logic [monitor_pkg::NUM_CORES-1:0]     event_valid_o,
   output logic [monitor_pkg::NUM_CORES-1:0][monitor_pkg::EVENT_KIND_W-1:0]
                                                 event_kind_o,
   output logic [monitor_pkg::NUM_CORES-1:0][trace_pkg::TRACE_DATA_W-1:0]
                                                 event_data_o,
   // Termination
   output logic [monitor_pkg::NUM_CORES-1:0]     core_done_o,
   output logic                                  term_all_o
);

   import trace_pkg::*;
   import monitor_pkg::*;

   logic [NUM_CORES-1:0]                   ev_valid_d;
   logic [NUM_CORES-1:0][EVENT_KIND_W-1:0] ev_kind_d;
   logic [NUM_CORES-1:0][TRACE_DATA_W-1:0] ev_data_d;
   logic [NUM_CORES-1:0]                   done_d;

   logic [NUM_CORES-1:0]                   ev_valid_q;
   logic [NUM_CORES-1:0][EVENT_KIND_W-1:0] ev_kind_q;
   logic [NUM_CORES-1:0][TRACE_DATA_W-1:0] ev_data_q;
   logic [NUM_CORES-1:0]                   done_q;
   logic                                   term_q;

   // Per core: decode the kind and pick the payload
   always_comb begin
      for (int c = 0; c < NUM_CORES; c++) begin
         ev_kind_d[c] = EV_NONE;
         ev_data_d[c] = r3_i[c];
         case (nop_code_i[c])
            NOP_EXIT:   ev_kind_d[c] = EV_EXIT;
            NOP_REPORT: ev_kind_d[c] = EV_REPORT;
            NOP_PUTC: begin
               ev_kind_d[c] = EV_PUTC;
               // Character sits in the low byte
               ev_data_d[c] = {{(TRACE_DATA_W-8){1'b0}}, r3_i[c][7:0]};
            end
            default:    ev_kind_d[c] = EV_NONE;
         endcase

         // A core that has exited stays silent
         ev_valid_d[c] = nop_hit_i[c] & ~done_q[c] & (ev_kind_d[c] != EV_NONE);

         done_d[c] = done_q[c] | (ev_valid_d[c] & (ev_kind_d[c] == EV_EXIT));
      end
   end

   // Control state
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ev_valid_q <= '0;
         done_q     <= '0;
         term_q     <= 1'b0;
      end else begin
         ev_valid_q <= ev_valid_d;
         done_q     <= done_d;
         // Rises with the last exit event
         term_q     <= &done_d;
      end
   end

   // Event payload, held between strobes
   always_ff @(posedge clk_i) begin
      for (int c = 0; c < NUM_CORES; c++) begin
         if (ev_valid_d[c]) begin
            ev_kind_q[c] <= ev_kind_d[c];
            ev_data_q[c] <= ev_data_d[c];
         end
      end
   end

   assign event_valid_o = ev_valid_q;
   assign event_kind_o  = ev_kind_q;
   assign event_data_o  = ev_data_q;
   assign core_done_o   = done_q;
   assign term_all_o    = term_q;

endmodule

// ==== files.f ====
trace_pkg.sv
monitor_pkg.sv
r3_checker.sv
nop_decoder.sv
event_combiner.sv
trace_monitor_top.sv
tb_trace_monitor.sv

// ==== monitor_pkg.sv ====
/*
 * Monitor package: core count and host event kind encoding
 */
package monitor_pkg;

   // Cores traced in the tile
   localparam int NUM_CORES = 2;

   // Event kind field
   localparam int EVENT_KIND_W = 2;

   // Kind 0 marks no event
   localparam logic [EVENT_KIND_W-1:0] EV_NONE   = 2'd0;
   localparam logic [EVENT_KIND_W-1:0] EV_EXIT   = 2'd1;
   localparam logic [EVENT_KIND_W-1:0] EV_REPORT = 2'd2;
   localparam logic [EVENT_KIND_W-1:0] EV_PUTC   = 2'd3;

endpackage

// ==== nop_decoder.sv ====
/*
 * Special nop decoder, flags host calls in the retired instruction stream
 */
`timescale 1ns/1ps

module nop_decoder (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   // Retired instruction of one core
   input  logic                             valid_i,
   input  logic [trace_pkg::TRACE_DATA_W-1:0] insn_i,
   // Registered host call
   output logic                             nop_hit_o,
   output logic [trace_pkg::NOP_CODE_W-1:0]   nop_code_o
);

   import trace_pkg::*;

   logic [NOP_PATTERN_W-1:0] insn_upper;
   logic [NOP_CODE_W-1:0]    insn_code;
   logic                     is_nop;
   logic                     code_known;
   logic                     hit_d;
   logic                     hit_q;
   logic [NOP_CODE_W-1:0]    code_q;

   // Split the word into pattern and code
   assign insn_upper = insn_i[TRACE_DATA_W-1:NOP_CODE_W];
   assign insn_code  = insn_i[NOP_CODE_W-1:0];

   assign is_nop = (insn_upper == NOP_PATTERN);

   // Only the host call codes count
   // Plain nop and unknown codes fall through
   always_comb begin
      case (insn_code)
         NOP_EXIT,
         NOP_REPORT,
         NOP_PUTC: code_known = 1'b1;
         default:  code_known = 1'b0;
      endcase
   end

   assign hit_d = valid_i & is_nop & code_known;

   // Hit strobe
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hit_q <= 1'b0;
      end else begin
         hit_q <= hit_d;
      end
   end

   // Code only matters together with the strobe
   always_ff @(posedge clk_i) begin
      if (hit_d) begin
         code_q <= insn_code;
      end
   end

   assign nop_hit_o  = hit_q;
   assign nop_code_o = code_q;

endmodule

// ==== r3_checker.sv ====
/*
 * r3 shadow register, follows the writeback stream of one core
 */
`timescale 1ns/1ps

module r3_checker (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   // Writeback trace of one core
   input  logic                             valid_i,
   input  logic                             we_i,
   input  logic [trace_pkg::TRACE_REG_W-1:0]  addr_i,
   input  logic [trace_pkg::TRACE_DATA_W-1:0] data_i,
   // Current shadow value
   output logic [trace_pkg::TRACE_DATA_W-1:0] r3_o
);

   import trace_pkg::*;

   logic                    r3_wr;
   logic [TRACE_DATA_W-1:0] r3_q;

   // Retired entry that writes back to r3
   assign r3_wr = valid_i & we_i & (addr_i == R3_INDEX);

   // Shadow copy, zero after reset like the core's register file
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r3_q <= '0;
      end else if (r3_wr) begin
         r3_q <= data_i;
      end
   end

   // New value visible one cycle after the writing entry
   assign r3_o = r3_q;

endmodule

// ==== tb_trace_monitor.sv ====
/*
 * Testbench for the trace monitor: replays stim file entries per core,
 * checks host events two cycles later and the exit and termination flags
 */
`timescale 1ns/1ps

module tb_trace_monitor;

   import trace_pkg::*;
   import monitor_pkg::*;

   localparam int          CLK_PERIOD  = 10;
   localparam int          RESET_CYCLE = 16;
   localparam int unsigned RAND_SEED   = 32'hde90_96d1;

   logic                                   clk_i = 1'b0;
   logic                                   rst_n_i;
   logic [NUM_CORES-1:0]                   trace_valid_i;
   logic [NUM_CORES-1:0][TRACE_DATA_W-1:0] trace_insn_i;
   logic [NUM_CORES-1:0]                   trace_wben_i;
   logic [NUM_CORES-1:0][TRACE_REG_W-1:0]  trace_wbreg_i;
   logic [NUM_CORES-1:0][TRACE_DATA_W-1:0] trace_wbdata_i;
   logic [NUM_CORES-1:0]                   event_valid_o;
   logic [NUM_CORES-1:0][EVENT_KIND_W-1:0] event_kind_o;
   logic [NUM_CORES-1:0][TRACE_DATA_W-1:0] event_data_o;
   logic [NUM_CORES-1:0]                   core_done_o;
   logic                                   term_all_o;

   // Stim file contents with one entry per cycle
   int                      stim_core[$];
   logic [TRACE_DATA_W-1:0] stim_insn[$];
   logic                    stim_wben[$];
   logic [TRACE_REG_W-1:0]  stim_wbreg[$];
   logic [TRACE_DATA_W-1:0] stim_wbdata[$];
   logic [EVENT_KIND_W-1:0] stim_kind[$];
   logic [TRACE_DATA_W-1:0] stim_data[$];
   logic                    stim_loaded = 1'b0;

   // Expected events in flight
   // Core -1 marks an idle cycle
   int                      exp_core_q[$];
   logic [EVENT_KIND_W-1:0] exp_kind_q[$];
   logic [TRACE_DATA_W-1:0] exp_data_q[$];
   logic [NUM_CORES-1:0]    exp_done;

   int mismatch_count = 0;
   int other_count    = 0;

   trace_monitor_top trace_monitor_top_inst (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .trace_valid_i  (trace_valid_i),
      .trace_insn_i   (trace_insn_i),
      .trace_wben_i   (trace_wben_i),
      .trace_wbreg_i  (trace_wbreg_i),
      .trace_wbdata_i (trace_wbdata_i),
      .event_valid_o  (event_valid_o),
      .event_kind_o   (event_kind_o),
      .event_data_o   (event_data_o),
      .core_done_o    (core_done_o),
      .term_all_o     (term_all_o)
   );

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   // Stim columns are core insn wben wbreg wbdata kind data
   // Lines starting with # are skipped
   task automatic load_stim_file();
      int                      fd;
      int                      n;
      int                      core_v;
      int                      wben_v;
      int                      wbreg_v;
      int                      kind_v;
      logic [TRACE_DATA_W-1:0] insn_v;
      logic [TRACE_DATA_W-1:0] wbdata_v;
      logic [TRACE_DATA_W-1:0] data_v;
      string                   line;
      fd = $fopen("trace_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file trace_stim.txt");
         other_count++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
               n = $sscanf(line, "%d %h %d %d %h %d %h", core_v, insn_v, wben_v,
                           wbreg_v, wbdata_v, kind_v, data_v);
               if (n == 7) begin
                  stim_core.push_back(core_v);
                  stim_insn.push_back(insn_v);
                  stim_wben.push_back(wben_v[0]);
                  stim_wbreg.push_back(wbreg_v[TRACE_REG_W-1:0]);
                  stim_wbdata.push_back(wbdata_v);
                  stim_kind.push_back(kind_v[EVENT_KIND_W-1:0]);
                  stim_data.push_back(data_v);
               end else if (n > 0) begin
                  $display("Stimulus line could not be read: %s", line);
                  other_count++;
               end
            end
         end
         $fclose(fd);
      end
      stim_loaded = 1'b1;
   endtask

   // One lane gets the entry and the others a host call that also writes r3
   task automatic drive_lanes(input int core, input logic [TRACE_DATA_W-1:0] insn,
                              input logic wben, input logic [TRACE_REG_W-1:0] wbreg,
                              input logic [TRACE_DATA_W-1:0] wbdata);
      logic [NOP_CODE_W-1:0] filler_code;
      for (int c = 0; c < NUM_CORES; c++) begin
         if (c == core) begin
            trace_valid_i[c]  <= 1'b1;
            trace_insn_i[c]   <= insn;
            trace_wben_i[c]   <= wben;
            trace_wbreg_i[c]  <= wbreg;
            trace_wbdata_i[c] <= wbdata;
         end else begin
            // Valid low must mask both the nop and the r3 write
            case ($urandom() % 3)
               0:       filler_code = NOP_EXIT;
               1:       filler_code = NOP_REPORT;
               default: filler_code = NOP_PUTC;
            endcase
            trace_valid_i[c]  <= 1'b0;
            trace_insn_i[c]   <= {NOP_PATTERN, filler_code};
            trace_wben_i[c]   <= 1'b1;
            trace_wbreg_i[c]  <= R3_INDEX;
            trace_wbdata_i[c] <= $urandom();
         end
      end
   endtask

   task automatic check_reset_state();
      assert (event_valid_o === '0) else begin
         $display("Mismatch at %0t: event_valid_o got %b expected %b",
                  $time, event_valid_o, {NUM_CORES{1'b0}});
         mismatch_count++;
      end
      assert (core_done_o === '0) else begin
         $display("Mismatch at %0t: core_done_o got %b expected %b",
                  $time, core_done_o, {NUM_CORES{1'b0}});
         mismatch_count++;
      end
      assert (term_all_o === 1'b0) else begin
         $display("Mismatch at %0t: term_all_o got %b expected 0", $time, term_all_o);
         mismatch_count++;
      end
   endtask

   // Compare outputs with the entry driven two cycles earlier
   task automatic check_events(input int core, input logic [EVENT_KIND_W-1:0] kind,
                               input logic [TRACE_DATA_W-1:0] data);
      logic exp_valid;
      for (int c = 0; c < NUM_CORES; c++) begin
         exp_valid = (c == core) && (kind != EV_NONE);
         assert (event_valid_o[c] === exp_valid) else begin
            $display("Mismatch at %0t: event_valid_o[%0d] got %b expected %b",
                     $time, c, event_valid_o[c], exp_valid);
            mismatch_count++;
         end
         if (exp_valid) begin
            assert (event_kind_o[c] === kind) else begin
               $display("Mismatch at %0t: event_kind_o[%0d] got %0d expected %0d",
                        $time, c, event_kind_o[c], kind);
               mismatch_count++;
            end
            assert (event_data_o[c] === data) else begin
               $display("Mismatch at %0t: event_data_o[%0d] got %h expected %h",
                        $time, c, event_data_o[c], data);
               mismatch_count++;
            end
            // Done flag rises with the exit event
            if (kind == EV_EXIT) begin
               exp_done[c] = 1'b1;
            end
         end
      end
      assert (core_done_o === exp_done) else begin
         $display("Mismatch at %0t: core_done_o got %b expected %b",
                  $time, core_done_o, exp_done);
         mismatch_count++;
      end
      assert (term_all_o === &exp_done) else begin
         $display("Mismatch at %0t: term_all_o got %b expected %b",
                  $time, term_all_o, &exp_done);
         mismatch_count++;
      end
   endtask

   // Drive on the rising edge and check on the falling edge
   task automatic run_cycle(input int core, input logic [TRACE_DATA_W-1:0] insn,
                            input logic wben, input logic [TRACE_REG_W-1:0] wbreg,
                            input logic [TRACE_DATA_W-1:0] wbdata,
                            input logic [EVENT_KIND_W-1:0] kind,
                            input logic [TRACE_DATA_W-1:0] data);
      int                      chk_core;
      logic [EVENT_KIND_W-1:0] chk_kind;
      logic [TRACE_DATA_W-1:0] chk_data;
      @(posedge clk_i);
      drive_lanes(core, insn, wben, wbreg, wbdata);
      exp_core_q.push_back(core);
      exp_kind_q.push_back(kind);
      exp_data_q.push_back(data);
      @(negedge clk_i);
      if (exp_core_q.size() > 2) begin
         chk_core = exp_core_q.pop_front();
         chk_kind = exp_kind_q.pop_front();
         chk_data = exp_data_q.pop_front();
         check_events(chk_core, chk_kind, chk_data);
      end
   endtask

   task automatic print_error_counts();
      $display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_count);
   endtask

   initial begin : main
      int unsigned seed_dummy;
      seed_dummy = $urandom(RAND_SEED);
      rst_n_i        = 1'b0;
      trace_valid_i  = '0;
      trace_insn_i   = '0;
      trace_wben_i   = '0;
      trace_wbreg_i  = '0;
      trace_wbdata_i = '0;
      exp_done       = '0;
      load_stim_file();
      repeat (RESET_CYCLE) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_reset_state();
      // Two idle cycles already behind the first entry
      for (int k = 0; k < 2; k++) begin
         exp_core_q.push_back(-1);
         exp_kind_q.push_back(EV_NONE);
         exp_data_q.push_back('0);
      end
      for (int i = 0; i < stim_core.size(); i++) begin
         run_cycle(stim_core[i], stim_insn[i], stim_wben[i], stim_wbreg[i],
                   stim_wbdata[i], stim_kind[i], stim_data[i]);
      end
      // Drain the pipeline
      repeat (4) begin
         run_cycle(-1, '0, 1'b0, '0, '0, EV_NONE, '0);
      end
      print_error_counts();
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Watchdog scaled to the stimulus length
   initial begin : watchdog
      int limit_ns;
      wait (stim_loaded);
      limit_ns = (stim_core.size() + 40) * CLK_PERIOD;
      #(limit_ns);
      $display("Timeout: the run did not finish within %0d ns", limit_ns);
      other_count++;
      print_error_counts();
      $display("Done: errors found");
      $finish;
   end

endmodule

// ==== trace_monitor_top.sv ====
/*
 * Trace monitor top: r3 shadow and nop decoder per core, shared combiner
 */
`timescale 1ns/1ps

module trace_monitor_top (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   // Writeback trace, one lane per core
   input  logic [monitor_pkg::NUM_CORES-1:0]     trace_valid_i,
   input  logic [monitor_pkg::NUM_CORES-1:0][trace_pkg::TRACE_DATA_W-1:0]
                                                 trace_insn_i,
   input  logic [monitor_pkg::NUM_CORES-1:0]     trace_wben_i,
   input  logic [monitor_pkg::NUM_CORES-1:0][trace_pkg::TRACE_REG_W-1:0]
                                                 trace_wbreg_i,
   input  logic [monitor_pkg::NUM_CORES-1:0][trace_pkg::TRACE_DATA_W-1:0]
                                                 trace_wbdata_i,
   // Host events
   output logic [monitor_pkg::NUM_CORES-1:0]     event_valid_o,
   output logic [monitor_pkg::NUM_CORES-1:0][monitor_pkg::EVENT_KIND_W-1:0]
                                                 event_kind_o,
   output logic [monitor_pkg::NUM_CORES-1:0][trace_pkg::TRACE_DATA_W-1:0]
                                                 event_data_o,
   output logic [monitor_pkg::NUM_CORES-1:0]     core_done_o,
   output logic                                  term_all_o
);

   import trace_pkg::*;
   import monitor_pkg::*;

   logic [NUM_CORES-1:0][TRACE_DATA_W-1:0] r3_value;
   logic [NUM_CORES-1:0]                   nop_hit;
   logic [NUM_CORES-1:0][NOP_CODE_W-1:0]   nop_code;

   // One shadow and one decoder per core, both one cycle deep
   for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
      r3_checker u_r3_checker (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .valid_i (trace_valid_i[i]),
         .we_i    (trace_wben_i[i]),
         .addr_i  (trace_wbreg_i[i]),
         .data_i  (trace_wbdata_i[i]),
         .r3_o    (r3_value[i])
      );

      nop_decoder u_nop_decoder (
         .clk_i      (clk_i),
         .rst_n_i    (rst_n_i),
         .valid_i    (trace_valid_i[i]),
         .insn_i     (trace_insn_i[i]),
         .nop_hit_o  (nop_hit[i]),
         .nop_code_o (nop_code[i])
      );
   end

   // Second stage, sees r3 from earlier entries only
   event_combiner u_event_combiner (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .nop_hit_i     (nop_hit),
      .nop_code_i    (nop_code),
      .r3_i          (r3_value),
      .event_valid_o (event_valid_o),
      .event_kind_o  (event_kind_o),
      .event_data_o  (event_data_o),
      .core_done_o   (core_done_o),
      .term_all_o    (term_all_o)
   );

endmodule

// ==== trace_pkg.sv ====
/*
 * Trace package: writeback trace field widths and special nop encoding
 */
package trace_pkg;

   // Instruction word and writeback data
   localparam int TRACE_DATA_W = 32;

   // Writeback register index
   localparam int TRACE_REG_W = 5;

   // Register shadowed per core, holds the argument of a host call
   localparam logic [TRACE_REG_W-1:0] R3_INDEX = 5'd3;

   // Special nop is split into a fixed upper half and a code in the lower half
   localparam int NOP_CODE_W = 16;
   localparam int NOP_PATTERN_W = TRACE_DATA_W - NOP_CODE_W;

   // Upper half of every special nop
   localparam logic [NOP_PATTERN_W-1:0] NOP_PATTERN = 16'h1500;

   // Codes in the lower half
   // Code 0 is a plain nop and means nothing to the host
   localparam logic [NOP_CODE_W-1:0] NOP_EXIT   = 16'h0001;
   localparam logic [NOP_CODE_W-1:0] NOP_REPORT = 16'h0002;
   localparam logic [NOP_CODE_W-1:0] NOP_PUTC   = 16'h0004;

endpackage

// ==== trace_stim.txt ====
# core insn(hex) wben wbreg wbdata(hex) exp_kind exp_data(hex)
# exp_kind: 0 none, 1 exit, 2 report, 3 putc
# r3 is zero after reset
0 15000002 0 0 00000000 2 00000000
1 15000002 0 0 00000000 2 00000000
# Report carries r3, other registers and wben low leave it alone
0 9c600000 1 3 cafe0123 0 00000000
0 15000002 0 0 00000000 2 cafe0123
0 9c800000 1 4 11111111 0 00000000
0 9c600000 0 3 22222222 0 00000000
0 15000002 0 0 00000000 2 cafe0123
# Putc keeps only the low byte, plain nop and unknown codes are silent
0 9c600000 1 3 12345641 0 00000000
0 15000004 0 0 00000000 3 00000041
0 15000000 0 0 00000000 0 00000000
0 15000003 0 0 00000000 0 00000000
0 14000002 0 0 00000000 0 00000000
0 15000008 0 0 00000000 0 00000000
# Interleaved cores keep separate r3 values
1 9c600000 1 3 0000beef 0 00000000
0 9c600000 1 3 00000a0d 0 00000000
1 15000002 0 0 00000000 2 0000beef
0 15000004 0 0 00000000 3 0000000d
1 15000004 0 0 00000000 3 000000ef
0 15000002 0 0 00000000 2 00000a0d
# Core 0 exits, later hits from it are dropped
0 9c600000 1 3 0000002a 0 00000000
0 15000001 0 0 00000000 1 0000002a
0 15000002 0 0 00000000 0 00000000
0 15000004 0 0 00000000 0 00000000
1 15000002 0 0 00000000 2 0000beef
0 15000001 0 0 00000000 0 00000000
0 9c600000 1 3 00000099 0 00000000
0 15000002 0 0 00000000 0 00000000
# Core 1 exits last and raises termination
1 9c600000 1 3 00000007 0 00000000
1 15000001 0 0 00000000 1 00000007
1 15000002 0 0 00000000 0 00000000
1 15000001 0 0 00000000 0 00000000
